// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP      = tb_gb_timer
FILELIST = vlog.f
PASS_MSG = No errors

.PHONY: sim clean

# Build, run and look for the pass line
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: rtl/axil_reg_slave.sv
`timescale 1ns/1ps
`include "timer_cfg.svh"

module axil_reg_slave (
  input  logic                         clk,
  input  logic                         reset,
  // Write address channel
  input  logic [`TIMER_ADDR_WIDTH-1:0] awaddr,
  input  logic                         awvalid,
  output logic                         awready,
  // Write data channel
  input  logic [`TIMER_DATA_WIDTH-1:0] wdata,
  input  logic                         wvalid,
  output logic                         wready,
  // Write response channel
  output logic                         bvalid,
  output logic [1:0]                   bresp,
  input  logic                         bready,
  // Read address channel
  input  logic [`TIMER_ADDR_WIDTH-1:0] araddr,
  input  logic                         arvalid,
  output logic                         arready,
  // Read data channel
  output logic                         rvalid,
  output logic [`TIMER_DATA_WIDTH-1:0] rdata,
  output logic [1:0]                   rresp,
  input  logic                         rready,
  // Internal register bus
  reg_bus_if.master                    regs
);

  localparam logic [2:0] IDLE  = 3'd0;
  localparam logic [2:0] WRITE = 3'd1;
  localparam logic [2:0] WRESP = 3'd2;
  localparam logic [2:0] READ  = 3'd3;
  localparam logic [2:0] RRESP = 3'd4;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  logic [2:0]                   state;
  logic [2:0]                   state_next;
  logic                         wr_accept;
  logic                         rd_accept;
  logic [`TIMER_ADDR_WIDTH-1:0] addr_q;
  logic [7:0]                   wdata_q;
  logic [`TIMER_DATA_WIDTH-1:0] rdata_q;

  // ============================================================
  // Handshake
  // ============================================================
  // Write needs both address and data present
  assign wr_accept = (state == IDLE) && awvalid && wvalid;
  // Write wins over a pending read
  assign rd_accept = (state == IDLE) && arvalid && !(awvalid && wvalid);

  assign awready = wr_accept;
  assign wready  = wr_accept;
  assign arready = rd_accept;

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (wr_accept) state_next = WRITE;
        else if (rd_accept) state_next = READ;
      end
      // One strobe cycle each
      WRITE: state_next = WRESP;
      READ:  state_next = RRESP;
      // Hold responses until taken
      WRESP: if (bready) state_next = IDLE;
      RRESP: if (rready) state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // ============================================================
  // Address, write byte and read data capture
  // ============================================================
  always_ff @(posedge clk) begin
    if (wr_accept) begin
      addr_q  <= awaddr;
      // Only the low byte reaches the registers
      wdata_q <= wdata[7:0];
    end else if (rd_accept) begin
      addr_q <= araddr;
    end
    // Sample the register mux during the read strobe
    if (state == READ) begin
      rdata_q <= {{(`TIMER_DATA_WIDTH-8){1'b0}}, regs.rdata};
    end
  end

  // Register bus drive
  assign regs.addr     = addr_q;
  assign regs.wdata    = wdata_q;
  assign regs.write_en = (state == WRITE);
  assign regs.read_en  = (state == READ);

  // Responses, always OKAY
  assign bvalid = (state == WRESP);
  assign bresp  = RESP_OKAY;
  assign rvalid = (state == RRESP);
  assign rdata  = rdata_q;
  assign rresp  = RESP_OKAY;

endmodule

// File: rtl/divider_counter.sv
`timescale 1ns/1ps
`include "timer_cfg.svh"

module divider_counter
  import timer_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  // DIV register write
  input  logic       div_clear,
  input  tac_t       tac,
  output logic [7:0] div_high,
  output t_phase_t   t_phase,
  // Gated tap level
  output logic       sel_bit,
  // Falling edge of the tap
  output logic       tick
);

  // Full 16-bit divider, one step per T-cycle
  logic [15:0] div_q;
  logic        sel_prev;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      div_q <= 16'h0000;
    end else if (div_clear) begin
      div_q <= `TIMER_DIV_RESET_VALUE;
    end else begin
      div_q <= div_q + 16'd1;
    end
  end

  // Only the upper byte is visible
  assign div_high = div_q[15:8];
  assign t_phase  = t_phase_t'(div_q[1:0]);

  // Tap select gated by the enable before edge detection as on the DMG
  always_comb begin
    case (tac.f.clk_sel)
      2'b00:   sel_bit = div_q[9] & tac.f.enable;
      2'b01:   sel_bit = div_q[3] & tac.f.enable;
      2'b10:   sel_bit = div_q[5] & tac.f.enable;
      default: sel_bit = div_q[7] & tac.f.enable;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sel_prev <= 1'b0;
    end else if (div_clear) begin
      // The timer block counts the edge from a DIV write
      sel_prev <= 1'b0;
    end else begin
      sel_prev <= sel_bit;
    end
  end

  // High to low edge of the gated level
  // Clearing the enable can also tick
  assign tick = sel_prev & ~sel_bit;

endmodule

// File: rtl/gb_timer_top.sv
`timescale 1ns/1ps
`include "timer_cfg.svh"

module gb_timer_top
  import timer_pkg::*;
(
  input  logic                         clk,
  input  logic                         reset,
  // AXI4-Lite slave
  input  logic [`TIMER_ADDR_WIDTH-1:0] awaddr,
  input  logic                         awvalid,
  output logic                         awready,
  input  logic [`TIMER_DATA_WIDTH-1:0] wdata,
  input  logic                         wvalid,
  output logic                         wready,
  output logic                         bvalid,
  output logic [1:0]                   bresp,
  input  logic                         bready,
  input  logic [`TIMER_ADDR_WIDTH-1:0] araddr,
  input  logic                         arvalid,
  output logic                         arready,
  output logic                         rvalid,
  output logic [`TIMER_DATA_WIDTH-1:0] rdata,
  output logic [1:0]                   rresp,
  input  logic                         rready,
  // Overflow interrupt pulse
  output logic                         timer_irq
);

  // Divider and timer block links
  tac_t       tac;
  logic       div_clear;
  logic [7:0] div_high;
  t_phase_t   t_phase;
  logic       sel_bit;
  logic       tick;

  reg_bus_if regs ();

  axil_reg_slave u_axil (
    .clk     (clk),
    .reset   (reset),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wvalid  (wvalid),
    .wready  (wready),
    .bvalid  (bvalid),
    .bresp   (bresp),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rvalid  (rvalid),
    .rdata   (rdata),
    .rresp   (rresp),
    .rready  (rready),
    .regs    (regs.master)
  );

  divider_counter u_div (
    .clk       (clk),
    .reset     (reset),
    .div_clear (div_clear),
    .tac       (tac),
    .div_high  (div_high),
    .t_phase   (t_phase),
    .sel_bit   (sel_bit),
    .tick      (tick)
  );

  timer_counter u_timer (
    .clk       (clk),
    .reset     (reset),
    .div_high  (div_high),
    .t_phase   (t_phase),
    .sel_bit   (sel_bit),
    .tick      (tick),
    .regs      (regs.slave),
    .tac       (tac),
    .div_clear (div_clear),
    .timer_irq (timer_irq)
  );

endmodule

// File: rtl/reg_bus_if.sv
`timescale 1ns/1ps
`include "timer_cfg.svh"

// Byte-wide register access bus
// Strobes are single cycle and never both high
interface reg_bus_if;

  logic [`TIMER_ADDR_WIDTH-1:0] addr;
  logic [7:0]                   wdata;
  logic                         write_en;
  logic                         read_en;
  // Combinational read data, FF when idle
  logic [7:0]                   rdata;

  // Bus host side
  modport master (output addr, wdata, write_en, read_en, input rdata);

  // Register block side
  modport slave (input addr, wdata, write_en, read_en, output rdata);

endinterface

// File: rtl/timer_cfg.svh
`ifndef TIMER_CFG_SVH
`define TIMER_CFG_SVH

// Register byte offsets, one 32-bit word each
`define TIMER_DIV_OFFSET  8'h00
`define TIMER_TIMA_OFFSET 8'h04
`define TIMER_TMA_OFFSET  8'h08
`define TIMER_TAC_OFFSET  8'h0C

// AXI4-Lite bus widths
`define TIMER_ADDR_WIDTH 8
`define TIMER_DATA_WIDTH 32

// Divider value after a DIV write
// Matches the DMG reset sequence offset
`define TIMER_DIV_RESET_VALUE 16'd4

`endif

// File: rtl/timer_counter.sv
`timescale 1ns/1ps
`include "timer_cfg.svh"

module timer_counter
  import timer_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] div_high,
  input  t_phase_t   t_phase,
  input  logic       sel_bit,
  input  logic       tick,
  // Register bus from the AXI side
  reg_bus_if.slave   regs,
  output tac_t       tac,
  output logic       div_clear,
  output logic       timer_irq
);

  logic [7:0] tima_q;
  logic [7:0] tma_q;
  tac_t       tac_q;
  tac_t       tac_wr_val;
  // Set for the M-cycle after a reload
  logic       reload_block;

  logic div_wr;
  logic tima_wr;
  logic tma_wr;
  logic tac_wr;

  // ============================================================
  // Address decode
  // ============================================================
  assign div_wr  = regs.write_en && (regs.addr == `TIMER_DIV_OFFSET);
  assign tima_wr = regs.write_en && (regs.addr == `TIMER_TIMA_OFFSET);
  assign tma_wr  = regs.write_en && (regs.addr == `TIMER_TMA_OFFSET);
  assign tac_wr  = regs.write_en && (regs.addr == `TIMER_TAC_OFFSET);

  // Any DIV write resets the divider
  assign div_clear = div_wr;

  // Upper five TAC bits stick at one
  always_comb begin
    tac_wr_val.raw      = regs.wdata;
    tac_wr_val.f.unused = '1;
  end

  assign tac = tac_q;

  // ============================================================
  // Registers, overflow and reload
  // ============================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      tima_q       <= 8'h00;
      tma_q        <= 8'h00;
      tac_q.raw    <= 8'hF8;
      timer_irq    <= 1'b0;
      reload_block <= 1'b0;
    end else begin
      // Interrupt is a single pulse
      timer_irq <= 1'b0;

      if (div_wr) begin
        // Divider reset drops a high tap
        // Counts as one extra falling edge
        if (sel_bit) begin
          tima_q <= tima_q + 8'd1;
          if (tima_q == 8'hFF) begin
            timer_irq <= 1'b1;
          end
        end
      end else if (tma_wr) begin
        tma_q <= regs.wdata;
        // New modulo lands in TIMA during reload
        if (reload_block) begin
          tima_q <= regs.wdata;
        end
      end else if (tac_wr) begin
        tac_q <= tac_wr_val;
      end else if (tima_wr && !reload_block) begin
        tima_q <= regs.wdata;
      end else if (tick) begin
        // Wraps to zero on overflow
        tima_q <= tima_q + 8'd1;
        if (tima_q == 8'hFF) begin
          timer_irq <= 1'b1;
        end
      end else if (t_phase == T1) begin
        // Delayed reload at the next M-cycle start
        if (tac_q.f.enable && tima_q == 8'h00) begin
          tima_q       <= tma_q;
          reload_block <= 1'b1;
        end else begin
          reload_block <= 1'b0;
        end
      end
    end
  end

  // ============================================================
  // Read mux
  // ============================================================
  always_comb begin
    regs.rdata = 8'hFF;
    if (regs.read_en) begin
      case (regs.addr)
        `TIMER_DIV_OFFSET:  regs.rdata = div_high;
        `TIMER_TIMA_OFFSET: regs.rdata = tima_q;
        `TIMER_TMA_OFFSET:  regs.rdata = tma_q;
        `TIMER_TAC_OFFSET:  regs.rdata = tac_q.raw;
        // Unmapped offsets float high
        default:            regs.rdata = 8'hFF;
      endcase
    end
  end

endmodule

// File: rtl/timer_pkg.sv
package timer_pkg;

  // T-cycle phase within one M-cycle
  // Taken from the two low divider bits
  typedef enum logic [1:0] {
    T1 = 2'd0,
    T2 = 2'd1,
    T3 = 2'd2,
    T4 = 2'd3
  } t_phase_t;

  // Timer control register
  // Clock select 00 -> 4096 Hz, 01 -> 262144 Hz
  // 10 -> 65536 Hz, 11 -> 16384 Hz
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      // Always read back as ones
      logic [4:0] unused;
      // Timer run enable
      logic       enable;
      // Divider tap select
      logic [1:0] clk_sel;
    } f;
  } tac_t;

endpackage

// File: tests/tb_gb_timer.sv
`timescale 1ns/1ps
`include "timer_cfg.svh"

module tb_gb_timer
  import timer_pkg::*;
();

  // Interrupt count window and expected rate
  localparam int IRQ_WINDOW   = 20000;
  localparam int IRQ_PERIOD   = 256 * 16;
  localparam int RESP_TIMEOUT = 100;

  logic                         clk = 1'b0;
  logic                         reset;
  logic [`TIMER_ADDR_WIDTH-1:0] awaddr;
  logic                         awvalid;
  logic                         awready;
  logic [`TIMER_DATA_WIDTH-1:0] wdata;
  logic                         wvalid;
  logic                         wready;
  logic                         bvalid;
  logic [1:0]                   bresp;
  logic                         bready;
  logic [`TIMER_ADDR_WIDTH-1:0] araddr;
  logic                         arvalid;
  logic                         arready;
  logic                         rvalid;
  logic [`TIMER_DATA_WIDTH-1:0] rdata;
  logic [1:0]                   rresp;
  logic                         rready;
  logic                         timer_irq;

  integer seed;
  int     errors = 0;
  int     tests_passed = 0;
  int     tests_failed = 0;
  int     irq_count = 0;
  int     cycle_count = 0;

  gb_timer_top uut (.*);

  // 8 ns clock
  always #4 clk = ~clk;

  // Free-running cycle count and interrupt pulse count
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (timer_irq) begin
      irq_count <= irq_count + 1;
    end
  end

  // ============================================================
  // Checks
  // ============================================================
  task automatic compare_byte(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_tac(input tac_t got, input tac_t exp);
    if (got.raw !== exp.raw) begin
      $display("Fail TAC: got %h expected %h", got.raw, exp.raw);
      errors++;
    end
  endtask

  task automatic check_range(input string name, input logic [7:0] got,
                             input logic [7:0] lo, input logic [7:0] hi);
    if (got < lo || got > hi) begin
      $display("Fail %s: got %h expected %h to %h", name, got, lo, hi);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    if (errors == err_before) begin
      tests_passed++;
      $display("Test %s: pass", name);
    end else begin
      tests_failed++;
      $display("Test %s: FAILED with %0d mismatches", name, errors - err_before);
    end
  endtask

  function automatic logic [7:0] rand_byte();
    return 8'($random(seed));
  endfunction

  // ============================================================
  // Reset and AXI4-Lite host
  // ============================================================
  task automatic reset_dut();
    reset <= 1'b1;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
  endtask

  task automatic axi_write(input logic [7:0] addr, input logic [7:0] data);
    int         waited;
    logic [7:0] delay;
    delay = rand_byte() % 8'd4;
    awaddr  <= addr;
    wdata   <= {{(`TIMER_DATA_WIDTH-8){1'b0}}, data};
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    waited = 0;
    // Address and data go in together
    do begin
      @(posedge clk);
      waited++;
    end while (!(awready && wready) && waited < RESP_TIMEOUT);
    if (!(awready && wready)) begin
      $display("Timeout waiting for write address and data ready at offset %h", addr);
      errors++;
    end
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    // Random hold-off on the B channel
    repeat (delay) @(posedge clk);
    bready <= 1'b1;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!bvalid && waited < RESP_TIMEOUT);
    if (!bvalid) begin
      $display("Timeout waiting for write response at offset %h", addr);
      errors++;
    end else begin
      compare_byte("bresp", {6'b0, bresp}, 8'h00);
    end
    bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [7:0] data);
    int         waited;
    logic [7:0] delay;
    delay = rand_byte() % 8'd4;
    data = 8'hXX;
    araddr  <= addr;
    arvalid <= 1'b1;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!arready && waited < RESP_TIMEOUT);
    if (!arready) begin
      $display("Timeout waiting for read address ready at offset %h", addr);
      errors++;
    end
    arvalid <= 1'b0;
    // Random hold-off on the R channel
    repeat (delay) @(posedge clk);
    rready <= 1'b1;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!rvalid && waited < RESP_TIMEOUT);
    if (!rvalid) begin
      $display("Timeout waiting for read data at offset %h", addr);
      errors++;
    end else begin
      data = rdata[7:0];
      compare_byte("rresp", {6'b0, rresp}, 8'h00);
    end
    rready <= 1'b0;
  endtask

  // ============================================================
  // Tests
  // ============================================================
  initial begin
    logic [7:0] val;
    logic [7:0] tma;
    logic [7:0] tima0;
    logic [7:0] prev;
    tac_t       tac_got;
    tac_t       tac_exp;
    int         err_before;
    int         irq_before;
    int         start_cycle;
    int         adv;
    int         waited;
    seed    = 32'h595d;
    reset   = 1'b1;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;

    // TMA and TAC readback and unmapped offsets
    reset_dut();
    err_before = errors;
    repeat (8) begin
      tma = rand_byte();
      axi_write(`TIMER_TMA_OFFSET, tma);
      axi_read(`TIMER_TMA_OFFSET, val);
      compare_byte("TMA", val, tma);
    end
    repeat (8) begin
      val = rand_byte();
      // Top five TAC bits read as ones
      tac_exp.raw = val | 8'hF8;
      axi_write(`TIMER_TAC_OFFSET, val);
      axi_read(`TIMER_TAC_OFFSET, val);
      tac_got.raw = val;
      compare_tac(tac_got, tac_exp);
    end
    axi_read(8'h10, val);
    compare_byte("unmapped 10", val, 8'hFF);
    axi_read(8'h02, val);
    compare_byte("unmapped 02", val, 8'hFF);
    axi_read(8'hFC, val);
    compare_byte("unmapped FC", val, 8'hFF);
    report_test("register readback", err_before);

    // DIV clear and growth
    reset_dut();
    err_before = errors;
    // Let the upper DIV byte move off zero before the clear
    repeat (600) @(posedge clk);
    axi_write(`TIMER_DIV_OFFSET, rand_byte());
    axi_read(`TIMER_DIV_OFFSET, prev);
    compare_byte("DIV", prev, 8'h00);
    repeat (3) begin
      // Over 512 clocks between reads
      repeat (520) @(posedge clk);
      axi_read(`TIMER_DIV_OFFSET, val);
      check_range("DIV", val, prev + 8'd1, 8'hFF);
      prev = val;
    end
    report_test("divider", err_before);

    // TIMA holds with the timer disabled
    reset_dut();
    err_before = errors;
    val = rand_byte();
    axi_write(`TIMER_TAC_OFFSET, val & 8'h03);
    tima0 = rand_byte();
    axi_write(`TIMER_TIMA_OFFSET, tima0);
    irq_before = irq_count;
    repeat (4) begin
      repeat (150) @(posedge clk);
      axi_read(`TIMER_TIMA_OFFSET, val);
      compare_byte("TIMA", val, tima0);
    end
    compare_byte("timer_irq pulses", 8'(irq_count - irq_before), 8'h00);
    report_test("timer disabled", err_before);

    // Overflow, interrupt and reload from TMA
    reset_dut();
    err_before = errors;
    tma = rand_byte() % 8'd241;
    axi_write(`TIMER_TMA_OFFSET, tma);
    axi_write(`TIMER_TIMA_OFFSET, 8'hFE);
    // Enable with the bit 3 tap
    // 16 cycles per tick
    axi_write(`TIMER_TAC_OFFSET, 8'h05);
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!timer_irq && waited < 200);
    if (!timer_irq) begin
      $display("Timer interrupt never arrived after TIMA overflow");
      errors++;
    end
    // Reload lands on the next T1
    repeat (4) @(posedge clk);
    axi_read(`TIMER_TIMA_OFFSET, val);
    check_range("TIMA", val, tma, tma + 8'd2);
    report_test("overflow and reload", err_before);

    // Interrupt rate with TMA at 0
    // 256 ticks per overflow
    reset_dut();
    err_before = errors;
    axi_write(`TIMER_TAC_OFFSET, 8'h05);
    irq_before = irq_count;
    repeat (IRQ_WINDOW) @(posedge clk);
    check_range("timer_irq pulses", 8'(irq_count - irq_before),
                8'(IRQ_WINDOW / IRQ_PERIOD - 1), 8'(IRQ_WINDOW / IRQ_PERIOD + 1));
    report_test("interrupt rate", err_before);

    // TIMA count rate after a write
    reset_dut();
    err_before = errors;
    tima0 = rand_byte() % 8'hF0;
    axi_write(`TIMER_TIMA_OFFSET, tima0);
    axi_write(`TIMER_TAC_OFFSET, 8'h05);
    start_cycle = cycle_count;
    repeat (200) @(posedge clk);
    adv = (cycle_count - start_cycle) / 16;
    axi_read(`TIMER_TIMA_OFFSET, val);
    check_range("TIMA", val, 8'(tima0 + adv - 1), 8'(tima0 + adv + 1));
    report_test("TIMA count", err_before);

    $display("Tests passed %0d, tests failed %0d, mismatches %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+rtl
rtl/timer_pkg.sv
rtl/reg_bus_if.sv
rtl/axil_reg_slave.sv
rtl/divider_counter.sv
rtl/timer_counter.sv
rtl/gb_timer_top.sv
tests/tb_gb_timer.sv
